// ==== all.f ====
logic/irq_return_pkg.sv
logic/ldst_cmd_fifo.sv
logic/spr_exchange.sv
logic/irq_return_ctrl.sv
logic/irq_return_unit.sv
sim/tb_irq_return.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the testbench with Verilator at command queue depths 2 and 4

cd "$(dirname "$0")" || exit 1

for depth in 2 4; do
	mdir="obj_dir_d$depth"
	log="sim_d$depth.log"
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_irq_return -GFIFO_DEPTH="$depth" \
		--Mdir "$mdir" -o tb_irq_return -f all.f
	if [ $? -ne 0 ]; then
		echo "Verilator build failed for depth $depth"
		exit 1
	fi
	"./$mdir/tb_irq_return" > "$log" 2>&1
	if [ $? -ne 0 ]; then
		echo "Simulation exited with an error at depth $depth, see $log"
		exit 1
	fi
	if ! grep -q "TEST RESULT: PASS" "$log"; then
		echo "Depth $depth failed, see $log"
		exit 1
	fi
	echo "Depth $depth passed"
done
exit 0

// ==== sim/tb_irq_return.sv ====
module tb_irq_return #(
	parameter int FIFO_DEPTH = 2
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_RETURNS = 48;	// Returns started over all tests
	localparam int FINISH_TIMEOUT = 150;

	typedef logic [127:0] value_t;
	typedef struct packed {
		logic has_exchange;
		logic spr_valid;
		irq_return_pkg::word_t spr;
		irq_return_pkg::ldst_cmd_t store;
		irq_return_pkg::ldst_cmd_t load;
	} expect_t;

	logic iCLOCK;
	logic inRESET;
	logic reset_sync;
	irq_return_pkg::word_t sysreg_ppsr;
	irq_return_pkg::word_t sysreg_spr;
	irq_return_pkg::word_t sysreg_tisr;
	irq_return_pkg::word_t sysreg_tidr;
	logic return_start;
	logic finish;
	logic finish_spr_valid;
	irq_return_pkg::word_t finish_spr;
	logic ldst_use;
	logic ldst_req;
	irq_return_pkg::ldst_cmd_t ldst_cmd;
	logic ldst_busy;
	logic ldst_ack;
	irq_return_pkg::word_t ldst_rdata;

	irq_return_pkg::word_t mem [irq_return_pkg::word_t];	// Load/store unit memory
	irq_return_pkg::ldst_cmd_t pending [$];	// Accepted with the ack still owed
	irq_return_pkg::ldst_cmd_t cmd_log [$];	// Issued during the current return
	expect_t exp_q [$];
	string name_q [$];
	int head_wait = -1;
	int req_without_use = 0;	// Requests seen while ldst_use was low
	logic hold_acks = 1'b0;
	logic random_busy = 1'b0;
	logic [31:0] lfsr = 32'h587ac5cd;
	int errors = 0;
	int finish_count = 0;
	int tests_run = 0;
	int tests_failed = 0;

	irq_return_unit #(.LDST_FIFO_DEPTH(FIFO_DEPTH)) dut (.*);

	initial begin
		iCLOCK = 1'b0;
		forever #10 iCLOCK = ~iCLOCK;
	end

	initial begin
		repeat (NUM_RETURNS * 200 + 10) @(posedge iCLOCK);
		$display("Watchdog expired, the test sequence did not complete in time");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// Galois LFSR for x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_next_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b) begin
			lfsr = lfsr ^ 32'h8020_0003;
		end
		return b;
	endfunction

	function automatic irq_return_pkg::word_t draw_bits(input int n);
		irq_return_pkg::word_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_next_bit()};
		end
		return v;
	endfunction

	// Content of a word never written
	function automatic irq_return_pkg::word_t fill_word(input irq_return_pkg::word_t a);
		return {a[15:0], a[31:16]} ^ 32'h9e37_79b9;
	endfunction

	// Expected finish and port traffic of one return
	function automatic expect_t expect_return(input irq_return_pkg::word_t ppsr, spr, tisr, tidr,
		input irq_return_pkg::word_t mem_img [irq_return_pkg::word_t]);
		expect_t e;
		irq_return_pkg::word_t base;
		base = tisr + (tidr << irq_return_pkg::TASK_RECORD_SHIFT);	// Task record
		e.has_exchange = ppsr[6:5] == irq_return_pkg::MODE_USER;
		e.spr_valid = e.has_exchange;
		e.store = {1'b1, irq_return_pkg::ORDER_WORD, irq_return_pkg::asid_t'(tidr),
			base + irq_return_pkg::KERNEL_SLOT_OFS, spr};
		e.load = {1'b0, irq_return_pkg::ORDER_WORD, irq_return_pkg::asid_t'(tidr),
			base + irq_return_pkg::USER_SLOT_OFS, 32'h0};
		if (!e.has_exchange) begin
			e.spr = spr;	// Kernel SPR stays
		end else if (mem_img.exists(e.load.addr)) begin
			e.spr = mem_img[e.load.addr];
		end else begin
			e.spr = fill_word(e.load.addr);
		end
		return e;
	endfunction

	task automatic check_value(input string what, input value_t expected, input value_t actual);
		if (expected !== actual) begin
			$display("[ERROR] %s: expected %0h, actual %0h", what, expected, actual);
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("%s: passed", name);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, errors - errors_before);
		end
	endtask

	// Requests are popped at this edge
	always @(posedge iCLOCK) begin
		if (inRESET && ldst_req) begin
			if (!ldst_use) begin
				req_without_use++;
			end
			pending.push_back(ldst_cmd);
			cmd_log.push_back(ldst_cmd);
			if (ldst_cmd.rw) begin
				mem[ldst_cmd.addr] = ldst_cmd.data;
			end
		end
	end

	// Load/store unit answers in order 1 to 4 cycles after the head
	always @(negedge iCLOCK) begin
		ldst_ack = 1'b0;
		ldst_rdata = '0;
		ldst_busy = random_busy ? (draw_bits(2) == 0) : 1'b0;
		if (pending.size() != 0) begin
			if (head_wait < 0) begin
				head_wait = int'(draw_bits(2));
			end
			if (head_wait > 0) begin
				head_wait--;
			end else if (!hold_acks) begin
				ldst_ack = 1'b1;
				if (!pending[0].rw) begin
					ldst_rdata = mem.exists(pending[0].addr) ? mem[pending[0].addr] :
						fill_word(pending[0].addr);
				end
				void'(pending.pop_front());
				head_wait = -1;
			end
		end
	end

	always @(negedge iCLOCK) begin : compare_finish
		expect_t e;
		string name;
		irq_return_pkg::ldst_cmd_t load_seen;
		if (inRESET && finish) begin
			if (exp_q.size() == 0) begin
				$display("Finish pulse seen with no return in progress");
				errors++;
			end else begin
				e = exp_q.pop_front();
				name = name_q.pop_front();
				check_value({name, " finish_spr_valid"}, e.spr_valid, finish_spr_valid);
				check_value({name, " finish_spr"}, e.spr, finish_spr);
				check_value({name, " ldst_use at finish"}, 0, ldst_use);
				check_value({name, " requests without ldst_use"}, 0, req_without_use);
				if (!e.has_exchange && cmd_log.size() != 0) begin
					$display("%s: kernel return issued %0d requests", name, cmd_log.size());
					errors++;
				end else if (e.has_exchange && cmd_log.size() != 2) begin
					$display("%s: wanted one store and one load, saw %0d requests", name,
						cmd_log.size());
					errors++;
				end else if (e.has_exchange) begin
					load_seen = cmd_log[1];
					load_seen.data = '0;	// Don't care on a load
					check_value({name, " store cmd"}, e.store, cmd_log[0]);
					check_value({name, " load cmd"}, e.load, load_seen);
					check_value({name, " kernel slot"}, e.store.data, mem[e.store.addr]);
				end
			end
			cmd_log.delete();
			req_without_use = 0;
			finish_count++;
		end
	end

	task automatic run_return(input string name, input irq_return_pkg::word_t ppsr, spr, tisr,
		tidr, input logic one_cycle);
		int seen;
		int waited;
		exp_q.push_back(expect_return(ppsr, spr, tisr, tidr, mem));
		name_q.push_back(name);
		seen = finish_count;
		@(negedge iCLOCK);
		sysreg_ppsr = ppsr;
		sysreg_spr = spr;
		sysreg_tisr = tisr;
		sysreg_tidr = tidr;
		return_start = 1'b1;
		@(negedge iCLOCK);
		return_start = 1'b0;
		if (one_cycle) begin
			check_value({name, " finish one cycle after start"}, 1, finish);
		end
		@(posedge iCLOCK);
		waited = 0;
		while (finish_count == seen && waited < FINISH_TIMEOUT) begin
			@(posedge iCLOCK);
			waited++;
		end
		if (finish_count == seen) begin
			$display("%s: no finish within %0d cycles", name, FINISH_TIMEOUT);
			errors++;
			exp_q.delete();
			name_q.delete();
		end
	endtask

	initial begin : test_sequence
		int err0;
		int seen;
		int waited;
		inRESET = 1'b0;
		reset_sync = 1'b0;
		sysreg_ppsr = '0;
		sysreg_spr = '0;
		sysreg_tisr = '0;
		sysreg_tidr = '0;
		return_start = 1'b0;
		ldst_busy = 1'b0;
		ldst_ack = 1'b0;
		ldst_rdata = '0;
		repeat (10) @(posedge iCLOCK);
		@(negedge iCLOCK);
		inRESET = 1'b1;
		@(posedge iCLOCK);
		$display("Command queue depth %0d", FIFO_DEPTH);

		err0 = errors;
		run_return("kernel_return", 32'h0000_0040, 32'h1234_5670, 32'h0010_0000, 32'd5, 1'b1);
		end_test("kernel_return", err0);

		err0 = errors;
		mem[32'h0022_003c] = 32'h0bad_f00d;	// User slot of task 0x4007
		run_return("user_return", 32'h0000_0060, 32'hcafe_0100, 32'h0020_0000, 32'h0000_4007,
			1'b0);
		end_test("user_return", err0);

		err0 = errors;
		random_busy = 1'b1;
		for (int i = 0; i < 4; i++) begin
			run_return($sformatf("busy_return_%0d", i), draw_bits(32) | 32'h0000_0060,
				draw_bits(32), draw_bits(32), draw_bits(16), 1'b0);
		end
		end_test("busy_user_returns", err0);

		// Cut an exchange after its store while its ack is held back
		err0 = errors;
		random_busy = 1'b0;
		hold_acks = 1'b1;
		@(negedge iCLOCK);
		sysreg_ppsr = 32'h0000_0060;
		sysreg_spr = 32'h5555_aaaa;
		sysreg_tisr = 32'h0040_0000;
		sysreg_tidr = 32'd9;
		return_start = 1'b1;
		@(negedge iCLOCK);
		return_start = 1'b0;
		waited = 0;
		while (cmd_log.size() == 0 && waited < FINISH_TIMEOUT) begin
			@(negedge iCLOCK);
			waited++;
		end
		if (cmd_log.size() == 0) begin
			$display("sync_flush: the store of the cut exchange was never issued");
			errors++;
		end
		reset_sync = 1'b1;
		seen = finish_count;
		@(negedge iCLOCK);
		reset_sync = 1'b0;
		repeat (4) @(posedge iCLOCK);
		check_value("sync_flush finish count", seen, finish_count);
		check_value("sync_flush ldst_use after flush", 0, ldst_use);
		hold_acks = 1'b0;	// Stray ack lands with the next start
		cmd_log.delete();
		req_without_use = 0;
		run_return("stray_ack_return", 32'h0000_0060, 32'h1357_9bdf, 32'h0040_0000, 32'd9, 1'b0);
		end_test("sync_flush", err0);

		err0 = errors;
		random_busy = 1'b1;
		for (int i = 0; i < 40; i++) begin
			run_return($sformatf("random_return_%0d", i), draw_bits(32), draw_bits(32),
				draw_bits(32), draw_bits(16), 1'b0);
		end
		end_test("random_returns", err0);

		$display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
		if (tests_failed == 0 && errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== logic/irq_return_unit.sv ====
module irq_return_unit #(
	parameter int LDST_FIFO_DEPTH = 2
) (
	input logic iCLOCK,
	input logic inRESET,
	input logic reset_sync,
	// System registers
	input irq_return_pkg::word_t sysreg_ppsr,
	input irq_return_pkg::word_t sysreg_spr,
	input irq_return_pkg::word_t sysreg_tisr,
	input irq_return_pkg::word_t sysreg_tidr,
	// Request and finish
	input logic return_start,
	output logic finish,
	output logic finish_spr_valid,
	output irq_return_pkg::word_t finish_spr,
	// Load/store port
	output logic ldst_use,
	output logic ldst_req,
	output irq_return_pkg::ldst_cmd_t ldst_cmd,
	input logic ldst_busy,
	input logic ldst_ack,
	input irq_return_pkg::word_t ldst_rdata
);

	logic exg_start;
	logic exg_done;
	irq_return_pkg::word_t exg_spr;
	logic push;
	irq_return_pkg::ldst_cmd_t push_cmd;

	irq_return_ctrl u_ctrl (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.reset_sync(reset_sync),
		.sysreg_ppsr(sysreg_ppsr),
		.sysreg_spr(sysreg_spr),
		.return_start(return_start),
		.exg_done(exg_done),
		.exg_spr(exg_spr),
		.exg_start(exg_start),
		.finish(finish),
		.finish_spr_valid(finish_spr_valid),
		.finish_spr(finish_spr)
	);

	spr_exchange u_exchange (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.reset_sync(reset_sync),
		.exg_start(exg_start),
		.sysreg_spr(sysreg_spr),
		.sysreg_tisr(sysreg_tisr),
		.sysreg_tidr(sysreg_tidr),
		.push(push),
		.push_cmd(push_cmd),
		.ldst_ack(ldst_ack),
		.ldst_rdata(ldst_rdata),
		.ldst_use(ldst_use),
		.exg_done(exg_done),
		.exg_spr(exg_spr)
	);

	ldst_cmd_fifo #(
		.DEPTH(LDST_FIFO_DEPTH)
	) u_cmd_fifo (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.reset_sync(reset_sync),
		.push(push),
		.push_cmd(push_cmd),
		.ldst_busy(ldst_busy),
		.ldst_req(ldst_req),
		.ldst_cmd(ldst_cmd)
	);

endmodule

// ==== logic/irq_return_ctrl.sv ====
module irq_return_ctrl (
	input logic iCLOCK,
	input logic inRESET,
	input logic reset_sync,
	// System registers
	input irq_return_pkg::word_t sysreg_ppsr,
	input irq_return_pkg::word_t sysreg_spr,
	// Request from pipeline control
	input logic return_start,
	// Exchange engine
	input logic exg_done,
	input irq_return_pkg::word_t exg_spr,
	output logic exg_start,
	// Finish
	output logic finish,
	output logic finish_spr_valid,
	output irq_return_pkg::word_t finish_spr
);

	irq_return_pkg::ret_state_t state;
	irq_return_pkg::ret_state_t state_next;
	irq_return_pkg::word_t b_spr;
	logic user_return;
	logic start_ok;

	// Kernel -> user needs the stack pointers swapped first
	assign user_return = irq_return_pkg::ppsr_mode(sysreg_ppsr) == irq_return_pkg::MODE_USER;
	assign start_ok = (state == irq_return_pkg::RET_IDLE) && return_start;

	always_comb begin
		state_next = state;
		case (state)
			irq_return_pkg::RET_IDLE: begin
				if (return_start) begin
					if (user_return) begin
						state_next = irq_return_pkg::RET_SPR_EXCHANGE;
					end else begin
						state_next = irq_return_pkg::RET_DONE;	// Kernel -> kernel, nothing to load
					end
				end
			end
			irq_return_pkg::RET_SPR_EXCHANGE: begin
				if (exg_done) begin
					state_next = irq_return_pkg::RET_DONE;
				end
			end
			irq_return_pkg::RET_DONE: begin
				state_next = irq_return_pkg::RET_IDLE;
			end
			default: begin
				state_next = irq_return_pkg::RET_IDLE;
			end
		endcase
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= irq_return_pkg::RET_IDLE;
		end else if (reset_sync) begin
			state <= irq_return_pkg::RET_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Strobes, registered so finish lands one cycle after the decision
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			exg_start <= 1'b0;
			finish <= 1'b0;
			finish_spr_valid <= 1'b0;
		end else if (reset_sync) begin
			exg_start <= 1'b0;
			finish <= 1'b0;
			finish_spr_valid <= 1'b0;
		end else begin
			exg_start <= start_ok && user_return;
			finish <= state_next == irq_return_pkg::RET_DONE;
			finish_spr_valid <= (state == irq_return_pkg::RET_SPR_EXCHANGE) && exg_done;
		end
	end

	// Result SPR
	always_ff @(posedge iCLOCK) begin
		if (start_ok) begin
			b_spr <= sysreg_spr;	// Current SPR, kept on a kernel return
		end else if ((state == irq_return_pkg::RET_SPR_EXCHANGE) && exg_done) begin
			b_spr <= exg_spr;	// User SPR from the task record
		end
	end

	assign finish_spr = b_spr;

	// Engine must only finish an exchange that this FSM started
	a_done_in_exchange: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		exg_done |-> (state == irq_return_pkg::RET_SPR_EXCHANGE)
	) else $error("exg_done outside SPR_EXCHANGE");

endmodule

// ==== logic/spr_exchange.sv ====
module spr_exchange (
	input logic iCLOCK,
	input logic inRESET,
	input logic reset_sync,
	// Request from the return FSM
	input logic exg_start,
	// System registers
	input irq_return_pkg::word_t sysreg_spr,
	input irq_return_pkg::word_t sysreg_tisr,
	input irq_return_pkg::word_t sysreg_tidr,
	// Command queue
	output logic push,
	output irq_return_pkg::ldst_cmd_t push_cmd,
	// Load/store response
	input logic ldst_ack,
	input irq_return_pkg::word_t ldst_rdata,
	output logic ldst_use,
	// Result
	output logic exg_done,
	output irq_return_pkg::word_t exg_spr
);

	irq_return_pkg::exg_state_t state;
	irq_return_pkg::word_t kernel_addr;
	irq_return_pkg::word_t user_addr;
	irq_return_pkg::word_t b_user_addr;
	irq_return_pkg::asid_t asid;
	irq_return_pkg::asid_t b_asid;
	logic start_ok;
	logic store_ack;
	logic load_ack;
	logic b_flush_seen;	// Port may still owe an ack from a flushed exchange

	assign kernel_addr = irq_return_pkg::task_slot_addr(sysreg_tisr, sysreg_tidr,
		irq_return_pkg::KERNEL_SLOT_OFS);
	assign user_addr = irq_return_pkg::task_slot_addr(sysreg_tisr, sysreg_tidr,
		irq_return_pkg::USER_SLOT_OFS);
	assign asid = sysreg_tidr[irq_return_pkg::ASID_W-1:0];

	assign start_ok = (state == irq_return_pkg::EXG_IDLE) && exg_start;
	assign store_ack = (state == irq_return_pkg::EXG_STORE_WAIT) && ldst_ack;
	assign load_ack = (state == irq_return_pkg::EXG_LOAD_WAIT) && ldst_ack;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= irq_return_pkg::EXG_IDLE;
			push <= 1'b0;
			exg_done <= 1'b0;
			b_flush_seen <= 1'b0;
		end else if (reset_sync) begin
			state <= irq_return_pkg::EXG_IDLE;
			push <= 1'b0;
			exg_done <= 1'b0;
			b_flush_seen <= 1'b1;
		end else begin
			push <= 1'b0;
			exg_done <= 1'b0;
			case (state)
				irq_return_pkg::EXG_IDLE: begin
					if (exg_start) begin
						push <= 1'b1;	// Kernel SPR store
						state <= irq_return_pkg::EXG_STORE_WAIT;
					end
				end
				irq_return_pkg::EXG_STORE_WAIT: begin
					if (ldst_ack) begin
						push <= 1'b1;	// User SPR load
						state <= irq_return_pkg::EXG_LOAD_WAIT;
					end
				end
				irq_return_pkg::EXG_LOAD_WAIT: begin
					if (ldst_ack) begin
						exg_done <= 1'b1;
						b_flush_seen <= 1'b0;
						state <= irq_return_pkg::EXG_IDLE;
					end
				end
				default: begin
					state <= irq_return_pkg::EXG_IDLE;
				end
			endcase
		end
	end

	// Command payload and captured load data
	always_ff @(posedge iCLOCK) begin
		if (start_ok) begin
			b_user_addr <= user_addr;
			b_asid <= asid;
			push_cmd <= '{
				rw: 1'b1,
				order: irq_return_pkg::ORDER_WORD,
				asid: asid,
				addr: kernel_addr,
				data: sysreg_spr
			};
		end else if (store_ack) begin
			push_cmd <= '{
				rw: 1'b0,
				order: irq_return_pkg::ORDER_WORD,
				asid: b_asid,
				addr: b_user_addr,
				data: '0
			};
		end
		if (load_ack) begin
			exg_spr <= ldst_rdata;
		end
	end

	assign ldst_use = state != irq_return_pkg::EXG_IDLE;

	// An idle engine only sees a leftover ack of an exchange cut off by reset_sync
	a_no_idle_ack: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		(ldst_ack && (state == irq_return_pkg::EXG_IDLE)) |-> b_flush_seen
	) else $error("ldst_ack with no outstanding command");

endmodule

// ==== logic/ldst_cmd_fifo.sv ====
module ldst_cmd_fifo #(
	parameter int DEPTH = 2
) (
	input logic iCLOCK,
	input logic inRESET,
	input logic reset_sync,
	// Producer side
	input logic push,
	input irq_return_pkg::ldst_cmd_t push_cmd,
	// Load/store port
	input logic ldst_busy,
	output logic ldst_req,
	output irq_return_pkg::ldst_cmd_t ldst_cmd
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	typedef logic [PTR_W-1:0] ptr_t;
	typedef logic [CNT_W-1:0] cnt_t;

	irq_return_pkg::ldst_cmd_t mem [DEPTH];
	ptr_t wr_ptr;
	ptr_t rd_ptr;
	cnt_t count;
	logic empty;
	logic full;
	logic push_ok;
	logic pop;

	// Wrap at DEPTH, which need not be a power of two
	function automatic ptr_t ptr_inc(input ptr_t p);
		return (p == ptr_t'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign empty = count == '0;
	assign full = count == cnt_t'(DEPTH);
	assign push_ok = push && !full;
	assign pop = !empty && !ldst_busy;	// Head waits while the port is busy

	assign ldst_req = pop;
	assign ldst_cmd = mem[rd_ptr];

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (reset_sync) begin
			wr_ptr <= '0;	// Flush
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push_ok) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			case ({push_ok, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (push_ok) begin
			mem[wr_ptr] <= push_cmd;
		end
	end

	// Producer keeps at most DEPTH commands in flight
	a_no_push_full: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		push |-> !full
	) else $error("push into a full command queue");

endmodule

// ==== logic/irq_return_pkg.sv ====
package irq_return_pkg;

	// Data path widths
	localparam int WORD_W = 32;
	localparam int ASID_W = 14;

	typedef logic [WORD_W-1:0] word_t;	// Data or address word
	typedef logic [ASID_W-1:0] asid_t;	// Address space id, low bits of TIDR

	// Processor mode field inside PPSR
	typedef logic [1:0] mode_t;
	localparam int PPSR_MODE_LSB = 5;	// PPSR[6:5]
	localparam mode_t MODE_USER = 2'h3;

	// Load/store access width
	typedef logic [1:0] order_t;
	localparam order_t ORDER_WORD = 2'h2;	// Only width ever issued here

	// Task information area layout
	localparam int TASK_RECORD_SHIFT = 3;	// 8 bytes per task record
	localparam word_t KERNEL_SLOT_OFS = 32'd0;
	localparam word_t USER_SLOT_OFS = 32'd4;

	// One load/store command as it leaves the queue, 81 bits
	typedef struct packed {
		logic rw;	// 1 = write
		order_t order;
		asid_t asid;
		word_t addr;
		word_t data;	// Store data, don't care on a load
	} ldst_cmd_t;

	// Return sequencer states
	typedef enum logic [1:0] {
		RET_IDLE,
		RET_SPR_EXCHANGE,
		RET_DONE
	} ret_state_t;

	// Exchange engine states
	typedef enum logic [1:0] {
		EXG_IDLE,
		EXG_STORE_WAIT,
		EXG_LOAD_WAIT
	} exg_state_t;

	// Mode bits of a saved status word
	function automatic mode_t ppsr_mode(input word_t ppsr);
		return ppsr[PPSR_MODE_LSB +: $bits(mode_t)];
	endfunction

	// Byte address of one slot in the running task's record
	function automatic word_t task_slot_addr(
		input word_t tisr,
		input word_t tidr,
		input word_t slot_ofs
	);
		word_t rec_base;
		rec_base = tisr + (tidr << TASK_RECORD_SHIFT);
		return rec_base + slot_ofs;
	endfunction

endpackage
